// ==== source/gat_dims_pkg.sv ====
`default_nettype none

package gat_dims_pkg;

  // ================================================
  // Layer dimensions
  // ================================================
  localparam int TOTAL_NODES     = 16;
  localparam int NUM_FEATURE_IN  = 11;
  localparam int NUM_FEATURE_OUT = 4;

  localparam int H_DEPTH   = 64;
  localparam int WGT_DEPTH = NUM_FEATURE_IN * NUM_FEATURE_OUT + 2 * NUM_FEATURE_OUT;

  // Attention vector sits right after W in the weight store
  localparam int ATT_BASE = NUM_FEATURE_IN * NUM_FEATURE_OUT;

  // LeakyReLU slope of 1/8
  localparam int LEAKY_SHIFT = 3;

  // ================================================
  // Field widths
  // ================================================
  localparam int DATA_W     = 8;
  localparam int COL_W      = 4;
  localparam int ROW_LEN_W  = 4;
  localparam int NODE_W     = 4;
  localparam int H_ADDR_W   = 6;
  localparam int WGT_ADDR_W = 6;
  localparam int WH_W       = 20;
  localparam int SCORE_W    = 32;

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic [COL_W-1:0]          col_t;
  typedef logic [ROW_LEN_W-1:0]      row_len_t;
  typedef logic [NODE_W-1:0]         node_t;
  typedef logic [H_ADDR_W-1:0]       h_addr_t;
  typedef logic [WGT_ADDR_W-1:0]     wgt_addr_t;
  typedef logic signed [WH_W-1:0]    wh_t;
  typedef logic signed [SCORE_W-1:0] score_t;

endpackage

`default_nettype wire

// ==== source/gat_types_pkg.sv ====
`default_nettype none

package gat_types_pkg;

  import gat_dims_pkg::*;

  // ================================================
  // Stored words and load ports
  // ================================================
  typedef struct packed {
    data_t value;
    col_t  col;
  } h_entry_t;

  // flag marks the source node that opens a subgraph
  typedef struct packed {
    row_len_t row_len;
    logic     flag;
  } node_info_t;

  typedef struct packed {
    logic     en;
    h_addr_t  addr;
    h_entry_t data;
  } h_wr_t;

  typedef struct packed {
    logic       en;
    node_t      addr;
    node_info_t data;
  } info_wr_t;

  typedef struct packed {
    logic      en;
    wgt_addr_t addr;
    data_t     data;
  } wgt_wr_t;

  // ================================================
  // Pipeline items
  // ================================================
  typedef struct packed {
    data_t value;
    col_t  col;
    logic  last;
    logic  flag;
    node_t node;
  } h_elem_t;

  typedef wh_t [NUM_FEATURE_OUT-1:0] wh_vec_t;
  typedef data_t [NUM_FEATURE_OUT-1:0] att_half_t;

  typedef struct packed {
    wh_vec_t wh;
    logic    flag;
    node_t   node;
  } wh_item_t;

  typedef struct packed {
    att_half_t a_src;
    att_half_t a_nbr;
  } att_vec_t;

endpackage

`default_nettype wire

// ==== source/gat_node_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module gat_node_decode import gat_dims_pkg::*, gat_types_pkg::*; (
  input  wire logic  clk,
  input  wire logic  arst_n,
  input  h_wr_t      h_wr,
  input  info_wr_t   info_wr,
  input  wire logic  h_load_done,
  input  wire logic  info_load_done,
  input  wire logic  wgt_load_done,
  output h_elem_t    elem,
  output logic       elem_valid
);

  typedef enum logic [1:0] {st_idle, st_read_info, st_stream, st_finish} state_t;

  state_t     state;
  node_t      node_idx;
  h_addr_t    h_addr;
  row_len_t   cnt;

  h_entry_t   h_mem [H_DEPTH];
  node_info_t info_mem [TOTAL_NODES];
  h_entry_t   h_q;
  node_info_t info_q;

  logic       rd_last;
  logic       rd_flag;
  logic       rd_zero;
  node_t      rd_node;

  logic       start;
  logic       node_empty;
  logic       issue_last;

  assign start      = h_load_done && info_load_done && wgt_load_done;
  assign node_empty = (info_q.row_len == '0);
  assign issue_last = node_empty || (row_len_t'(cnt + 1'b1) == info_q.row_len);

  // ================================================
  // Load memories, one cycle read
  // ================================================
  always_ff @(posedge clk) begin
    if (h_wr.en) h_mem[h_wr.addr] <= h_wr.data;
    if (info_wr.en) info_mem[info_wr.addr] <= info_wr.data;
    info_q <= info_mem[node_idx];
    h_q    <= h_mem[h_addr];
  end

  // ================================================
  // Node walker
  // ================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      node_idx   <= '0;
      h_addr     <= '0;
      cnt        <= '0;
      elem_valid <= 1'b0;
      rd_last    <= 1'b0;
      rd_flag    <= 1'b0;
      rd_zero    <= 1'b0;
      rd_node    <= '0;
    end else begin
      elem_valid <= (state == st_stream);
      rd_last    <= issue_last;
      rd_flag    <= info_q.flag;
      rd_zero    <= node_empty;
      rd_node    <= node_idx;
      case (state)
        st_idle: begin
          if (start) begin
            node_idx <= '0;
            h_addr   <= '0;
            state    <= st_read_info;
          end
        end
        st_read_info: begin
          cnt   <= '0;
          state <= st_stream;
        end
        st_stream: begin
          // Empty rows emit one zero element and consume no entry
          if (!node_empty) h_addr <= h_addr + 1'b1;
          cnt <= cnt + 1'b1;
          if (issue_last) begin
            if (node_idx == node_t'(TOTAL_NODES - 1)) begin
              state <= st_finish;
            end else begin
              node_idx <= node_idx + 1'b1;
              state    <= st_read_info;
            end
          end
        end
        default: state <= st_finish;
      endcase
    end
  end

  always_comb begin
    elem.value = rd_zero ? data_t'(0) : h_q.value;
    elem.col   = rd_zero ? col_t'(0) : h_q.col;
    elem.last  = rd_last;
    elem.flag  = rd_flag;
    elem.node  = rd_node;
  end

endmodule

`default_nettype wire

// ==== source/gat_wh_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module gat_wh_execute import gat_dims_pkg::*, gat_types_pkg::*; (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wgt_wr_t   wgt_wr,
  input  h_elem_t   elem,
  input  wire logic elem_valid,
  output wh_item_t  item,
  output logic      item_valid,
  output att_vec_t  att
);

  data_t   wgt [WGT_DEPTH];
  wh_vec_t acc;
  wh_vec_t sum;
  logic    node_end;

  assign node_end = elem_valid && elem.last;

  // ================================================
  // Weight store
  // ================================================
  always_ff @(posedge clk) begin
    if (wgt_wr.en) wgt[wgt_wr.addr] <= wgt_wr.data;
  end

  // W row is selected by the element column
  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      sum[k] = acc[k] + elem.value * wgt[wgt_addr_t'(elem.col * NUM_FEATURE_OUT + k)];
    end
  end

  always_comb begin
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      att.a_src[k] = wgt[wgt_addr_t'(ATT_BASE + k)];
      att.a_nbr[k] = wgt[wgt_addr_t'(ATT_BASE + NUM_FEATURE_OUT + k)];
    end
  end

  // ================================================
  // Accumulate and hand off
  // ================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc        <= '0;
      item_valid <= 1'b0;
    end else begin
      item_valid <= node_end;
      if (elem_valid) begin
        // Clear on last so the next node starts from zero
        acc <= elem.last ? wh_vec_t'(0) : sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (node_end) begin
      item.wh   <= sum;
      item.flag <= elem.flag;
      item.node <= elem.node;
    end
  end

endmodule

`default_nettype wire

// ==== source/gat_score_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module gat_score_result import gat_dims_pkg::*, gat_types_pkg::*; (
  input  wire logic clk,
  input  wire logic arst_n,
  input  wh_item_t  item,
  input  wire logic item_valid,
  input  att_vec_t  att,
  input  node_t     score_addr,
  output score_t    score_data,
  output logic      done
);

  score_t score_mem [TOTAL_NODES];

  score_t p_src;
  score_t p_nbr;
  score_t src_term;
  score_t raw_score;
  score_t leaky_score;
  score_t src_hold;

  logic   wr_en;
  node_t  wr_node;
  score_t wr_score;

  // ================================================
  // Attention score
  // ================================================
  always_comb begin
    p_src = '0;
    p_nbr = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      p_src = p_src + score_t'(att.a_src[k]) * score_t'(item.wh[k]);
      p_nbr = p_nbr + score_t'(att.a_nbr[k]) * score_t'(item.wh[k]);
    end
    // A source node pairs with itself
    src_term  = item.flag ? p_src : src_hold;
    raw_score = src_term + p_nbr;
    // Arithmetic shift floors negative scores
    leaky_score = raw_score[SCORE_W-1] ? (raw_score >>> LEAKY_SHIFT) : raw_score;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      src_hold <= '0;
      wr_en    <= 1'b0;
      done     <= 1'b0;
    end else begin
      wr_en <= item_valid;
      if (item_valid && item.flag) src_hold <= p_src;
      if (wr_en && (wr_node == node_t'(TOTAL_NODES - 1))) done <= 1'b1;
    end
  end

  // ================================================
  // Score memory
  // ================================================
  always_ff @(posedge clk) begin
    if (item_valid) begin
      wr_node  <= item.node;
      wr_score <= leaky_score;
    end
    if (wr_en) score_mem[wr_node] <= wr_score;
    score_data <= score_mem[score_addr];
  end

endmodule

`default_nettype wire

// ==== source/gat_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module gat_core_top import gat_dims_pkg::*, gat_types_pkg::*; (
  input  wire logic clk,
  input  wire logic arst_n,
  input  h_wr_t     h_wr,
  input  info_wr_t  info_wr,
  input  wgt_wr_t   wgt_wr,
  input  wire logic h_load_done,
  input  wire logic info_load_done,
  input  wire logic wgt_load_done,
  input  node_t     score_addr,
  output score_t    score_data,
  output logic      done
);

  h_elem_t  elem;
  logic     elem_valid;
  wh_item_t item;
  logic     item_valid;
  att_vec_t att;

  // ================================================
  // Stage 1: sparse row decode
  // ================================================
  gat_node_decode u_node_decode (
    .clk            (clk            ),
    .arst_n         (arst_n         ),
    .h_wr           (h_wr           ),
    .info_wr        (info_wr        ),
    .h_load_done    (h_load_done    ),
    .info_load_done (info_load_done ),
    .wgt_load_done  (wgt_load_done  ),
    .elem           (elem           ),
    .elem_valid     (elem_valid     )
  );

  // ================================================
  // Stage 2: WH projection
  // ================================================
  gat_wh_execute u_wh_execute (
    .clk        (clk        ),
    .arst_n     (arst_n     ),
    .wgt_wr     (wgt_wr     ),
    .elem       (elem       ),
    .elem_valid (elem_valid ),
    .item       (item       ),
    .item_valid (item_valid ),
    .att        (att        )
  );

  // Stage 3
  gat_score_result u_score_result (
    .clk        (clk        ),
    .arst_n     (arst_n     ),
    .item       (item       ),
    .item_valid (item_valid ),
    .att        (att        ),
    .score_addr (score_addr ),
    .score_data (score_data ),
    .done       (done       )
  );

endmodule

`default_nettype wire

// ==== dv/gat_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module gat_core_tb import gat_dims_pkg::*, gat_types_pkg::*; ();

  localparam int RUN_CYCLES  = TOTAL_NODES * (NUM_FEATURE_IN + 3) + 20;
  localparam int LOAD_CYCLES = H_DEPTH + TOTAL_NODES + WGT_DEPTH + 2 * TOTAL_NODES + 8;
  localparam int NUM_RUNS    = 5;
  localparam int CYCLE_LIMIT = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES);

  logic     clk;
  logic     arst_n;
  h_wr_t    h_wr;
  info_wr_t info_wr;
  wgt_wr_t  wgt_wr;
  logic     h_load_done;
  logic     info_load_done;
  logic     wgt_load_done;
  node_t    score_addr;
  score_t   score_data;
  logic     done;

  integer seed;
  int     errors;
  int     checks;
  int     cycles;

  // Graph image and expected scores
  int     h_val [H_DEPTH];
  int     h_col [H_DEPTH];
  int     h_used;
  int     row_len [TOTAL_NODES];
  int     flag [TOTAL_NODES];
  int     wgt_val [WGT_DEPTH];
  score_t exp_score [TOTAL_NODES];

  gat_core_top dut_i (
    .clk            (clk            ),
    .arst_n         (arst_n         ),
    .h_wr           (h_wr           ),
    .info_wr        (info_wr        ),
    .wgt_wr         (wgt_wr         ),
    .h_load_done    (h_load_done    ),
    .info_load_done (info_load_done ),
    .wgt_load_done  (wgt_load_done  ),
    .score_addr     (score_addr     ),
    .score_data     (score_data     ),
    .done           (done           )
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, done never rose (checks %0d, errors %0d)",
               cycles, checks, errors);
      $display("Verification failed");
      $finish;
    end
  end

  // ================================================
  // Reference model
  // ================================================
  function automatic int rand_below(input int n);
    rand_below = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic longint leaky_relu(input longint x);
    longint div;
    div = longint'(1) << LEAKY_SHIFT;
    // Floor division for negative scores
    if (x >= 0) leaky_relu = x;
    else leaky_relu = -((-x + div - 1) / div);
  endfunction

  task automatic add_entry(input int value, input int col);
    h_val[h_used] = value;
    h_col[h_used] = col;
    h_used++;
  endtask

  task automatic compute_expected();
    longint wh [NUM_FEATURE_OUT];
    longint p_src;
    longint p_nbr;
    longint src;
    int     addr;
    addr = 0;
    src  = 0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) wh[k] = 0;
      for (int i = 0; i < row_len[n]; i++) begin
        for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
          wh[k] += h_val[addr] * wgt_val[h_col[addr] * NUM_FEATURE_OUT + k];
        end
        addr++;
      end
      p_src = 0;
      p_nbr = 0;
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        p_src += wgt_val[ATT_BASE + k] * wh[k];
        p_nbr += wgt_val[ATT_BASE + NUM_FEATURE_OUT + k] * wh[k];
      end
      if (flag[n] != 0) src = p_src;
      exp_score[n] = score_t'(leaky_relu(src + p_nbr));
    end
  endtask

  // ================================================
  // Graph builders
  // ================================================
  task automatic build_handmade();
    h_used = 0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      flag[n]    = (n % 4 == 0);
      row_len[n] = 1 + n % 3;
      for (int i = 0; i < row_len[n]; i++) begin
        add_entry(1 + (n + i) % 4, (n + 3 * i) % NUM_FEATURE_IN);
      end
    end
    for (int a = 0; a < WGT_DEPTH; a++) begin
      wgt_val[a] = (a < ATT_BASE) ? 1 + a % 3 : 1 + a % NUM_FEATURE_OUT;
    end
  endtask

  task automatic build_random();
    int left;
    int max_len;
    h_used = 0;
    left   = 0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      if (left == 0) begin
        flag[n] = 1;
        left    = 1 + rand_below(6);
      end else begin
        flag[n] = 0;
      end
      left--;
      // Leave room for one entry per remaining node
      max_len = H_DEPTH - h_used - (TOTAL_NODES - 1 - n);
      if (max_len > NUM_FEATURE_IN) max_len = NUM_FEATURE_IN;
      row_len[n] = 1 + rand_below(max_len);
      for (int i = 0; i < row_len[n]; i++) begin
        add_entry(rand_below(256) - 128, rand_below(NUM_FEATURE_IN));
      end
    end
    for (int a = 0; a < WGT_DEPTH; a++) wgt_val[a] = rand_below(256) - 128;
  endtask

  task automatic build_negative();
    h_used = 0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      flag[n] = (n == 0 || n == 5 || n == 10);
      // Node 5 is a source with an empty row
      row_len[n] = (n % 4 == 1 || n == TOTAL_NODES - 1) ? 0 : 1 + n % 5;
      for (int i = 0; i < row_len[n]; i++) begin
        add_entry(2 + i % 3, (2 * n + i) % NUM_FEATURE_IN);
      end
    end
    for (int a = 0; a < ATT_BASE; a++) wgt_val[a] = -1 - a % 4;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      wgt_val[ATT_BASE + k]                   = 1;
      wgt_val[ATT_BASE + NUM_FEATURE_OUT + k] = (k % 2 == 0) ? 3 : -1;
    end
  endtask

  // ================================================
  // DUT drivers
  // ================================================
  task automatic apply_reset();
    @(posedge clk);
    arst_n         <= 1'b0;
    h_load_done    <= 1'b0;
    info_load_done <= 1'b0;
    wgt_load_done  <= 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic load_memories();
    for (int a = 0; a < h_used; a++) begin
      @(posedge clk);
      h_wr.en         <= 1'b1;
      h_wr.addr       <= h_addr_t'(a);
      h_wr.data.value <= data_t'(h_val[a]);
      h_wr.data.col   <= col_t'(h_col[a]);
    end
    @(posedge clk);
    h_wr.en <= 1'b0;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      @(posedge clk);
      info_wr.en           <= 1'b1;
      info_wr.addr         <= node_t'(n);
      info_wr.data.row_len <= row_len_t'(row_len[n]);
      info_wr.data.flag    <= (flag[n] != 0);
    end
    @(posedge clk);
    info_wr.en <= 1'b0;
    for (int a = 0; a < WGT_DEPTH; a++) begin
      @(posedge clk);
      wgt_wr.en   <= 1'b1;
      wgt_wr.addr <= wgt_addr_t'(a);
      wgt_wr.data <= data_t'(wgt_val[a]);
    end
    @(posedge clk);
    wgt_wr.en      <= 1'b0;
    h_load_done    <= 1'b1;
    info_load_done <= 1'b1;
    wgt_load_done  <= 1'b1;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (done !== 1'b1) @(negedge clk);
  endtask

  task automatic check_scores(input string name);
    score_t got;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      @(posedge clk);
      score_addr <= node_t'(n);
      @(posedge clk);
      @(negedge clk);
      got = score_data;
      checks++;
      if (got !== exp_score[n]) begin
        errors++;
        $display("Fail at %0t: %s node %0d score %0d, expected %0d",
                 $time, name, n, got, exp_score[n]);
      end
    end
  endtask

  task automatic run_layer(input string name);
    compute_expected();
    load_memories();
    wait_done();
    check_scores(name);
  endtask

  // ================================================
  // Tests
  // ================================================
  task automatic test_idle_after_reset();
    apply_reset();
    repeat (20) begin
      @(negedge clk);
      checks++;
      if (done !== 1'b0) begin
        errors++;
        $display("Fail at %0t: done is high while the load-done levels are low", $time);
      end
    end
  endtask

  task automatic test_handmade_graph();
    build_handmade();
    apply_reset();
    run_layer("handmade");
  endtask

  task automatic test_random_graph();
    build_random();
    apply_reset();
    run_layer("random");
  endtask

  task automatic test_empty_rows_negative();
    build_negative();
    apply_reset();
    run_layer("empty_negative");
  endtask

  task automatic test_reload();
    checks++;
    if (done !== 1'b1) begin
      errors++;
      $display("Fail at %0t: done is low before the reset", $time);
    end
    build_random();
    apply_reset();
    @(negedge clk);
    checks++;
    if (done !== 1'b0) begin
      errors++;
      $display("Fail at %0t: done did not fall at reset", $time);
    end
    run_layer("reload");
  endtask

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    h_wr           = '0;
    info_wr        = '0;
    wgt_wr         = '0;
    h_load_done    = 1'b0;
    info_load_done = 1'b0;
    wgt_load_done  = 1'b0;
    score_addr     = '0;
    seed           = 32'h8da0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;

    test_idle_after_reset();
    test_handmade_graph();
    test_random_graph();
    test_empty_rows_negative();
    test_reload();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/gat_dims_pkg.sv
source/gat_types_pkg.sv
source/gat_node_decode.sv
source/gat_wh_execute.sv
source/gat_score_result.sv
source/gat_core_top.sv
dv/gat_core_tb.sv

// ==== Bender.yml ====
package:
  name: gat_core

sources:
  - source/gat_dims_pkg.sv
  - source/gat_types_pkg.sv
  - source/gat_node_decode.sv
  - source/gat_wh_execute.sv
  - source/gat_score_result.sv
  - source/gat_core_top.sv
  - target: test
    files:
      - dv/gat_core_tb.sv
